// ==== rv_core.f ====
+incdir+source
source/rv_pkg.sv
source/rv_alu.sv
source/rv_control.sv
source/rv_imm_gen.sv
source/rv_regfile.sv
source/rv_core.sv
verification/rv_core_sva.sv
verification/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - source

sources:
  - files:
      - source/rv_pkg.sv
      - source/rv_alu.sv
      - source/rv_control.sv
      - source/rv_imm_gen.sv
      - source/rv_regfile.sv
      - source/rv_core.sv
  - target: test
    files:
      - verification/rv_core_sva.sv
      - verification/rv_core_tb.sv

// ==== verification/rv_core_tb.sv ====
`include "rv_params.svh"

module rv_core_tb
    import rv_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD     = 20;
    localparam int FIRST_SLOT = 16;   // ram word of the first checked store
    localparam int MEM_WORDS  = 2 ** `ADDR_WIDTH;

    logic      CLK;
    logic      RESET_N;
    instr_t    q_rom;
    mem_addr_t ADDR_ROM;
    mem_addr_t ADDR_RAM;
    word_t     q_ram;
    word_t     q_w;
    logic      ENABLE_W;

    word_t     rom [MEM_WORDS];
    word_t     ram [MEM_WORDS];
    instr_t    prog [$];       // program, one word per entry
    string     exp_name [$];   // expected stores, in program order
    mem_addr_t exp_addr [$];
    word_t     exp_data [$];
    int        slot = FIRST_SLOT;
    word_t     rand_state = 32'd12803;

    rv_core i_rv_core (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .q_rom    (q_rom),
        .ADDR_ROM (ADDR_ROM),
        .ADDR_RAM (ADDR_RAM),
        .q_ram    (q_ram),
        .q_w      (q_w),
        .ENABLE_W (ENABLE_W)
    );

    // ********************
    // memory models
    assign q_rom = rom[ADDR_ROM];   // combinational reads
    assign q_ram = ram[ADDR_RAM];

    always @(posedge CLK) begin
        if (ENABLE_W) begin
            ram[ADDR_RAM] <= q_w;
        end
    end

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // ********************
    // rv32i encoders
    function automatic instr_t r_type(logic [6:0] f7, reg_idx_t rs2, rs1, logic [2:0] f3,
                                      reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, `OPC_R};
    endfunction

    function automatic instr_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                      reg_idx_t rd, opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t s_type(logic [11:0] imm, reg_idx_t rs2, rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OPC_STORE};   // sw only
    endfunction

    function automatic instr_t b_type(logic [12:0] imm, reg_idx_t rs2, rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic instr_t j_type(logic [20:0] imm, reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
    endfunction

    function automatic instr_t u_type(logic [19:0] imm, reg_idx_t rd, opcode_t opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t lcg_next();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    // two's complement compare from the sign bits
    function automatic word_t signed_lt(word_t x, word_t y);
        if (x[31] != y[31]) begin
            return word_t'(x[31]);
        end
        return word_t'(x < y);
    endfunction

    function automatic word_t arith_shift_right(word_t x, int n);
        word_t fill;
        fill = x[31] ? ~(32'hffff_ffff >> n) : '0;   // copies of the sign bit
        return (x >> n) | fill;
    endfunction

    // ********************
    // program building
    task automatic add_instr(instr_t w);
        prog.push_back(w);
    endtask

    task automatic expect_store(string name, reg_idx_t rs, word_t value);
        add_instr(s_type(12'(slot * 4), rs, 5'd0));   // sw rs, slot*4(x0)
        exp_name.push_back(name);
        exp_addr.push_back(mem_addr_t'(slot));
        exp_data.push_back(value);
        slot++;
    endtask

    task automatic poison_store();
        add_instr(s_type(12'h7fc, 5'd2, 5'd0));   // must never execute
    endtask

    task automatic load_const(reg_idx_t rd, word_t value);
        word_t upper;
        upper = value + 32'h800;   // addi sign-extends the low part
        add_instr(u_type(upper[31:12], rd, `OPC_LUI));
        add_instr(i_type(value[11:0], rd, 3'b000, rd, `OPC_IMM));
    endtask

    task automatic alu_r_case(string name, logic [6:0] f7, logic [2:0] f3, word_t expected);
        add_instr(r_type(f7, 5'd2, 5'd1, f3, 5'd3));   // x3 = x1 op x2
        expect_store(name, 5'd3, expected);
    endtask

    task automatic alu_i_case(string name, logic [11:0] imm, logic [2:0] f3, word_t expected);
        add_instr(i_type(imm, 5'd1, f3, 5'd3, `OPC_IMM));
        expect_store(name, 5'd3, expected);
    endtask

    // ********************
    // checking
    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("Error: test %s, expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    initial begin
        word_t a;
        word_t b;
        word_t ra;
        word_t rb;
        int    limit;
        int    cycles;
        int    seen;
        a       = 32'h8765_4321;   // negative on purpose
        b       = 32'h0f0f_0f05;   // shift amount 5
        cycles  = 0;
        seen    = 0;
        RESET_N = 1'b0;

        expect_store("reset_x5", 5'd5, '0);   // x5 not written yet
        load_const(5'd1, a);
        load_const(5'd2, b);
        expect_store("lui_addi", 5'd1, a);
        alu_r_case("add", 7'h00, 3'b000, a + b);
        alu_r_case("sub", 7'h20, 3'b000, a - b);
        alu_r_case("and", 7'h00, 3'b111, a & b);
        alu_r_case("or", 7'h00, 3'b110, a | b);
        alu_r_case("xor", 7'h00, 3'b100, a ^ b);
        alu_r_case("slt", 7'h00, 3'b010, signed_lt(a, b));
        alu_r_case("sll", 7'h00, 3'b001, a << b[4:0]);
        alu_r_case("srl", 7'h00, 3'b101, a >> b[4:0]);
        alu_r_case("sra", 7'h20, 3'b101, arith_shift_right(a, b[4:0]));
        alu_i_case("addi", 12'hff9, 3'b000, a + 32'hffff_fff9);
        alu_i_case("andi", 12'h0f0, 3'b111, a & 32'h0000_00f0);
        alu_i_case("ori", 12'h80f, 3'b110, a | 32'hffff_f80f);
        alu_i_case("xori", 12'hfff, 3'b100, ~a);
        alu_i_case("slti", 12'h000, 3'b010, signed_lt(a, '0));
        alu_i_case("slli", 12'h003, 3'b001, a << 3);
        alu_i_case("srli", 12'h004, 3'b101, a >> 4);
        alu_i_case("srai", 12'h404, 3'b101, arith_shift_right(a, 4));

        // memory round trip through x4
        expect_store("mem_sw", 5'd1, a);
        add_instr(i_type(12'((slot - 1) * 4), 5'd0, 3'b010, 5'd4, `OPC_LOAD));
        expect_store("mem_lw", 5'd4, a);

        // ********************
        // control flow
        add_instr(b_type(13'd8, 5'd1, 5'd1, 3'b000));   // beq taken
        poison_store();
        expect_store("beq_taken", 5'd1, a);
        add_instr(b_type(13'd8, 5'd2, 5'd1, 3'b001));   // bne taken
        poison_store();
        expect_store("bne_taken", 5'd2, b);
        add_instr(b_type(13'd8, 5'd2, 5'd1, 3'b000));   // beq falls through
        expect_store("beq_fall", 5'd1, a);
        add_instr(b_type(13'd8, 5'd1, 5'd1, 3'b001));   // bne falls through
        expect_store("bne_fall", 5'd2, b);
        ra = word_t'(prog.size() * 4 + 4);   // link of the jal below
        add_instr(j_type(21'd8, 5'd6));
        poison_store();
        expect_store("jal_link", 5'd6, ra);
        add_instr(u_type(20'habcde, 5'd7, `OPC_LUI));
        expect_store("lui", 5'd7, 32'habcd_e000);
        rb = word_t'(prog.size() * 4) + 32'h0001_2000;
        add_instr(u_type(20'h00012, 5'd7, `OPC_AUIPC));
        expect_store("auipc", 5'd7, rb);

        // random operand pairs
        for (int k = 0; k < 4; k++) begin
            ra = lcg_next();
            rb = lcg_next();
            load_const(5'd1, ra);
            load_const(5'd2, rb);
            alu_r_case($sformatf("rand%0d_add", k), 7'h00, 3'b000, ra + rb);
            alu_r_case($sformatf("rand%0d_xor", k), 7'h00, 3'b100, ra ^ rb);
            alu_r_case($sformatf("rand%0d_slt", k), 7'h00, 3'b010, signed_lt(ra, rb));
        end
        add_instr(j_type(21'd0, 5'd0));   // jal x0, 0 parks the core

        foreach (rom[i]) begin
            rom[i] = (i < prog.size()) ? prog[i] : j_type(21'd0, 5'd0);
            ram[i] = word_t'(i) * 32'h9e37_79b9;
        end

        repeat (2) @(posedge CLK);
        @(negedge CLK);
        check_value("reset_pc", '0, word_t'(ADDR_ROM));
        @(posedge CLK);
        #1 RESET_N = 1'b1;

        // ********************
        // store monitor, one entry per store strobe
        limit = prog.size() + 20;
        while (seen < exp_data.size() && cycles < limit) begin
            @(negedge CLK);
            cycles++;
            if (i_rv_core.i_rv_core_sva.fail_count != 0) begin
                $display("A bound assertion failed before cycle %0d", cycles);
                abort_run();
            end
            if (ENABLE_W) begin
                check_value({exp_name[seen], "_addr"}, word_t'(exp_addr[seen]),
                            word_t'(ADDR_RAM));
                check_value(exp_name[seen], exp_data[seen], q_w);
                seen++;
            end
        end
        if (seen == exp_data.size()) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Timeout: only %0d of %0d expected stores seen in %0d cycles",
                     seen, exp_data.size(), cycles);
            abort_run();
        end
    end

endmodule

// ==== verification/rv_core_sva.sv ====
`include "rv_params.svh"

module rv_core_sva
    import rv_pkg::*;
(
    input logic      CLK,
    input logic      RESET_N,
    input logic      reg_write,
    input logic      ENABLE_W,
    input mem_addr_t ADDR_ROM,
    input reg_idx_t  rs1,
    input reg_idx_t  rd,
    input word_t     rdata1,
    input word_t     wb_data
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;   // failed assertions so far

    // a store never writes back
    no_store_and_writeback: assert property (@(posedge CLK) disable iff (!RESET_N)
        !(ENABLE_W && reg_write))
        else begin
            fail_count++;
            $error("store and register write decoded in the same cycle");
        end

    rom_addr_known: assert property (@(posedge CLK) disable iff (!RESET_N)
        !$isunknown(ADDR_ROM))
        else begin
            fail_count++;
            $error("ADDR_ROM is unknown");
        end

    // a written register reads back on the next instruction
    reg_read_back: assert property (@(posedge CLK) disable iff (!RESET_N)
        (reg_write && rd != '0) |=> (rs1 != $past(rd) || rdata1 == $past(wb_data)))
        else begin
            fail_count++;
            $error("register read back differs from the value written");
        end

endmodule

bind rv_core rv_core_sva i_rv_core_sva (.*);

// ==== source/rv_core.sv ====
`include "rv_params.svh"

module rv_core
    import rv_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET_N,
    input  instr_t    q_rom,
    output mem_addr_t ADDR_ROM,
    output mem_addr_t ADDR_RAM,
    input  word_t     q_ram,
    output word_t     q_w,
    output logic      ENABLE_W
);

    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    pc_t        pc, pc_plus4, pc_target, pc_next;
    word_t      imm, rdata1, rdata2;
    word_t      op_a, op_b, alu_result, wb_data;
    logic       alu_zero;
    logic       reg_write, alu_src_imm, branch;
    logic       take_branch, jump;
    logic [1:0] op_a_sel, wb_sel;
    alu_op_t    alu_op;

    // instruction fields
    opcode_t    opcode;
    logic [2:0] funct3;
    reg_idx_t   rs1, rs2, rd;

    assign opcode = q_rom[6:0];
    assign funct3 = q_rom[14:12];
    assign rd     = q_rom[11:7];
    assign rs1    = q_rom[19:15];
    assign rs2    = q_rom[24:20];

    // ********************
    // decode
    rv_control i_rv_control (
        .opcode      (opcode),
        .funct3      (funct3),
        .funct7_5    (q_rom[30]),
        .reg_write   (reg_write),
        .mem_write   (ENABLE_W),   // store strobe straight from decode
        .alu_src_imm (alu_src_imm),
        .branch      (branch),
        .op_a_sel    (op_a_sel),
        .wb_sel      (wb_sel),
        .alu_op      (alu_op)
    );

    rv_imm_gen i_rv_imm_gen (
        .instr (q_rom),
        .imm   (imm)
    );

    rv_regfile i_rv_regfile (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .wdata   (wb_data),
        .we      (reg_write),
        .rdata1  (rdata1),
        .rdata2  (rdata2)
    );

    // ********************
    // execute
    always_comb begin
        case (op_a_sel)
            `OPA_PC:   op_a = word_t'(pc);   // auipc, jal
            `OPA_ZERO: op_a = '0;            // lui
            default:   op_a = rdata1;
        endcase
    end

    assign op_b = alu_src_imm ? imm : rdata2;

    rv_alu i_rv_alu (
        .a      (op_a),
        .b      (op_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // ********************
    // next pc
    assign pc_plus4    = pc + pc_t'(4);
    assign pc_target   = pc + imm[$bits(pc_t)-1:0];
    assign jump        = (opcode == `OPC_JAL);
    assign take_branch = branch && ((funct3 == F3_BEQ && alu_zero) ||
                                    (funct3 == F3_BNE && !alu_zero));
    assign pc_next     = (take_branch || jump) ? pc_target : pc_plus4;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // writeback select
    always_comb begin
        case (wb_sel)
            `WB_MEM:  wb_data = q_ram;
            `WB_LINK: wb_data = word_t'(pc_plus4);   // zero-extended link
            default:  wb_data = alu_result;
        endcase
    end

    // memory ports, byte addresses dropped to words
    assign ADDR_ROM = pc[$bits(pc_t)-1:2];
    assign ADDR_RAM = alu_result[$bits(mem_addr_t)+1:2];
    assign q_w      = rdata2;

endmodule

// ==== source/rv_regfile.sv ====
module rv_regfile
    import rv_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET_N,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  word_t    wdata,
    input  logic     we,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [32];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            regs <= '{default: '0};
        end else if (we && rd != '0) begin   // x0 stays zero
            regs[rd] <= wdata;
        end
    end

    // combinational read ports
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== source/rv_imm_gen.sv ====
`include "rv_params.svh"

module rv_imm_gen
    import rv_pkg::*;
(
    input  instr_t instr,
    output word_t  imm
);

    opcode_t opcode;

    assign opcode = instr[6:0];

    always_comb begin
        case (opcode)
            `OPC_STORE:  // s-type
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            `OPC_BRANCH: // b-type, bit 0 always zero
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            `OPC_JAL:    // j-type
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            `OPC_LUI,
            `OPC_AUIPC:  // u-type, upper 20 bits
                imm = {instr[31:12], 12'b0};
            default:     // i-type, loads and alu immediates
                imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

// ==== source/rv_control.sv ====
`include "rv_params.svh"

module rv_control
    import rv_pkg::*;
(
    input  opcode_t    opcode,
    input  logic [2:0] funct3,
    input  logic       funct7_5,
    output logic       reg_write,
    output logic       mem_write,
    output logic       alu_src_imm,
    output logic       branch,
    output logic [1:0] op_a_sel,
    output logic [1:0] wb_sel,
    output alu_op_t    alu_op
);

    logic is_alu_instr;   // r-type or i-type alu, funct3 picks the op

    // ********************
    // main decoder
    always_comb begin
        reg_write   = 1'b0;   // unknown opcodes fall through with no writes
        mem_write   = 1'b0;
        alu_src_imm = 1'b0;
        branch      = 1'b0;
        op_a_sel    = `OPA_REG;
        wb_sel      = `WB_ALU;
        case (opcode)
            `OPC_R: begin
                reg_write = 1'b1;
            end
            `OPC_IMM: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
            end
            `OPC_LOAD: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                wb_sel      = `WB_MEM;
            end
            `OPC_STORE: begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;   // rs1 + offset
            end
            `OPC_BRANCH: begin
                branch = 1'b1;        // compares rs1 against rs2
            end
            `OPC_JAL: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                op_a_sel    = `OPA_PC;
                wb_sel      = `WB_LINK;
            end
            `OPC_LUI: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                op_a_sel    = `OPA_ZERO;   // 0 + imm
            end
            `OPC_AUIPC: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                op_a_sel    = `OPA_PC;
            end
            default: ;
        endcase
    end

    assign is_alu_instr = (opcode == `OPC_R) || (opcode == `OPC_IMM);

    // ********************
    // alu operation
    always_comb begin
        alu_op = `ALU_ADD;   // loads, stores, jal, lui, auipc
        if (opcode == `OPC_BRANCH) begin
            alu_op = `ALU_SUB;
        end else if (is_alu_instr) begin
            case (funct3)
                3'b000:  alu_op = (opcode == `OPC_R && funct7_5) ? `ALU_SUB : `ALU_ADD;
                3'b001:  alu_op = `ALU_SLL;
                3'b010:  alu_op = `ALU_SLT;
                3'b100:  alu_op = `ALU_XOR;
                3'b101:  alu_op = funct7_5 ? `ALU_SRA : `ALU_SRL;   // srai too
                3'b110:  alu_op = `ALU_OR;
                3'b111:  alu_op = `ALU_AND;
                default: alu_op = `ALU_ADD;   // sltu not supported
            endcase
        end
    end

endmodule

// ==== source/rv_alu.sv ====
`include "rv_params.svh"

module rv_alu
    import rv_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result,
    output logic    zero
);

    logic [4:0] shamt;
    logic       lt_signed;

    assign shamt     = b[4:0];   // rv32 shifts use the low five bits only
    assign lt_signed = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            `ALU_ADD:    result = a + b;
            `ALU_SUB:    result = a - b;   // also the branch compare
            `ALU_AND:    result = a & b;
            `ALU_OR:     result = a | b;
            `ALU_XOR:    result = a ^ b;
            `ALU_SLT:    result = {{(`XLEN-1){1'b0}}, lt_signed};
            `ALU_SLL:    result = a << shamt;
            `ALU_SRL:    result = a >> shamt;
            `ALU_SRA:    result = $signed(a) >>> shamt;   // keeps sign bit
            `ALU_PASS_B: result = b;
            default:     result = '0;
        endcase
    end

    assign zero = (result == '0);   // beq/bne decide on this

endmodule

// ==== source/rv_pkg.sv ====
package rv_pkg;

`include "rv_params.svh"

    // data path
    typedef logic [`XLEN-1:0]         word_t;
    typedef logic [31:0]              instr_t;

    // addresses
    typedef logic [`ADDR_WIDTH+1:0]   pc_t;        // byte address
    typedef logic [`ADDR_WIDTH-1:0]   mem_addr_t;  // word address

    // instruction fields
    typedef logic [4:0]               reg_idx_t;
    typedef logic [6:0]               opcode_t;

    // alu select, see ALU_* codes
    typedef logic [3:0]               alu_op_t;

endpackage

// ==== source/rv_params.svh ====
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`define XLEN       32
`define ADDR_WIDTH 10   // word address into rom and ram

// ********************
// alu operation codes
`define ALU_ADD    4'd0
`define ALU_SUB    4'd1
`define ALU_AND    4'd2
`define ALU_OR     4'd3
`define ALU_XOR    4'd4
`define ALU_SLT    4'd5   // signed compare
`define ALU_SLL    4'd6
`define ALU_SRL    4'd7
`define ALU_SRA    4'd8
`define ALU_PASS_B 4'd9

// ********************
// rv32i opcodes in use
`define OPC_R      7'b0110011
`define OPC_IMM    7'b0010011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111

// ********************
// datapath select codes
`define OPA_REG    2'd0
`define OPA_PC     2'd1
`define OPA_ZERO   2'd2
`define WB_ALU     2'd0
`define WB_MEM     2'd1
`define WB_LINK    2'd2   // pc+4 for jal

`endif
